// ==== rtl/shot_pkg.sv ====
`default_nettype none

package shot_pkg;

        // table and field sizes
        localparam int SHOT_SLOTS = 4;
        localparam int SLOT_BITS  = 2;
        localparam int POS_BITS   = 4;

        localparam logic [POS_BITS-1:0] POS_MAX   = 4'd15; // right edge of the field
        localparam logic [POS_BITS-1:0] POS_RESET = 4'd8;  // ship starts mid field

        // kind of shot, stored beside the position
        typedef enum logic [1:0] {
                kind_single = 2'b00,
                kind_spread = 2'b01,
                kind_laser  = 2'b10,
                kind_bomb   = 2'b11
        } shot_kind_e;

        // control states, also shown on the debug output
        typedef enum logic [2:0] {
                st_init        = 3'd0,
                st_idle        = 3'd1,
                st_clear_count = 3'd2,
                st_check_slot  = 3'd3,
                st_next_slot   = 3'd4,
                st_settle      = 3'd5,
                st_save_shot   = 3'd6,
                st_signal_done = 3'd7
        } reg_state_e;

endpackage

`default_nettype wire

// ==== rtl/ship_position.sv ====
`default_nettype none

module ship_position
        import shot_pkg::*;
(
        input  wire logic                clock,
        input  wire logic                reset,
        input  wire logic                move_left,  // one-cycle pulse
        input  wire logic                move_right, // one-cycle pulse
        output logic [POS_BITS-1:0]      ship_pos
);

        logic at_left;
        logic at_right;
        logic go_left;
        logic go_right;

        assign at_left  = (ship_pos == '0);
        assign at_right = (ship_pos == POS_MAX);

        // both pulses together cancel out
        assign go_left  = move_left  && !move_right && !at_left;
        assign go_right = move_right && !move_left  && !at_right;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        ship_pos <= POS_RESET;
                end else if (go_left) begin
                        ship_pos <= ship_pos - 1'b1;
                end else if (go_right) begin
                        ship_pos <= ship_pos + 1'b1;
                end
                // otherwise hold, which also covers saturation at either edge
        end

endmodule

`default_nettype wire

// ==== rtl/slot_counter.sv ====
`default_nettype none

module slot_counter
        import shot_pkg::*;
(
        input  wire logic                 clock,
        input  wire logic                 reset,
        input  wire logic                 slot_clear, // back to slot 0
        input  wire logic                 slot_count, // step to the next slot
        output logic [SLOT_BITS-1:0]      slot_index,
        output logic                      slot_last   // ripple carry at the last slot
);

        localparam logic [SLOT_BITS-1:0] LAST_INDEX = SLOT_BITS'(SHOT_SLOTS - 1);

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        slot_index <= '0;
                end else if (slot_clear) begin
                        slot_index <= '0; // clear wins over count
                end else if (slot_count) begin
                        slot_index <= slot_index + 1'b1;
                end
        end

        assign slot_last = (slot_index == LAST_INDEX);

endmodule

`default_nettype wire

// ==== rtl/shot_table.sv ====
`default_nettype none

module shot_table
        import shot_pkg::*;
(
        input  wire logic                  clock,
        input  wire logic                  reset,

        // write side, driven by the scan
        input  wire logic [SLOT_BITS-1:0]  slot_index,
        input  wire logic                  save_shot,
        input  wire logic [POS_BITS-1:0]   ship_pos,
        input  wire shot_kind_e            save_kind,

        // frees a slot once its shot is gone
        input  wire logic                  retire,
        input  wire logic [SLOT_BITS-1:0]  retire_slot,

        input  wire logic [SLOT_BITS-1:0]  read_slot,

        output logic                       slot_busy,   // flag of the scanned slot
        output logic [SHOT_SLOTS-1:0]      slot_loaded,
        output logic [POS_BITS-1:0]        read_position,
        output shot_kind_e                 read_kind
);

        logic [POS_BITS-1:0] pos_mem  [SHOT_SLOTS];
        shot_kind_e          kind_mem [SHOT_SLOTS];

        // payload storage, position and kind captured at the save
        always_ff @(posedge clock) begin
                if (save_shot) begin
                        pos_mem[slot_index]  <= ship_pos;
                        kind_mem[slot_index] <= save_kind;
                end
        end

        // loaded flags
        // the save is applied last so it wins over a retire of the same slot
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        slot_loaded <= '0;
                end else begin
                        if (retire) begin
                                slot_loaded[retire_slot] <= 1'b0;
                        end
                        if (save_shot) begin
                                slot_loaded[slot_index] <= 1'b1;
                        end
                end
        end

        assign slot_busy = slot_loaded[slot_index];

        // combinational read port
        assign read_position = pos_mem[read_slot];
        assign read_kind     = kind_mem[read_slot];

endmodule

`default_nettype wire

// ==== rtl/shot_register_control.sv ====
`default_nettype none

module shot_register_control
        import shot_pkg::*;
(
        input  wire logic                  clock,
        input  wire logic                  reset,
        input  wire logic                  fire,        // only looked at in idle
        input  wire shot_kind_e            fire_kind,
        input  wire logic                  slot_busy,
        input  wire logic                  slot_last,
        input  wire logic [SLOT_BITS-1:0]  slot_index,

        output logic                       slot_clear,
        output logic                       slot_count,
        output logic                       save_shot,
        output shot_kind_e                 save_kind,   // kind held for the whole request
        output logic                       shot_done,
        output logic                       shot_saved,
        output logic [SLOT_BITS-1:0]       saved_slot,
        output reg_state_e                 db_state
);

        reg_state_e state;
        reg_state_e next_state;
        logic       saved_flag; // set when the current request wrote a slot

        // state register
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state <= st_init;
                end else begin
                        state <= next_state;
                end
        end

        // next state
        always_comb begin
                next_state = state;
                unique case (state)
                        st_init:        next_state = st_idle;
                        st_idle:        next_state = fire ? st_clear_count : st_idle;
                        st_clear_count: next_state = st_settle;
                        // settle gives the cleared index a cycle before the first check
                        st_settle:      next_state = st_check_slot;
                        st_check_slot: begin
                                if (!slot_busy) begin
                                        next_state = st_save_shot;
                                end else if (slot_last) begin
                                        next_state = st_signal_done; // table full, shot dropped
                                end else begin
                                        next_state = st_next_slot;
                                end
                        end
                        st_next_slot:   next_state = st_check_slot; // counter steps on this edge
                        st_save_shot:   next_state = st_signal_done;
                        st_signal_done: next_state = st_idle;
                        default:        next_state = st_init;
                endcase
        end

        // request data, captured when fire is accepted and at the save
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        save_kind  <= kind_single;
                        saved_slot <= '0;
                        saved_flag <= 1'b0;
                end else begin
                        if (state == st_idle && fire) begin
                                save_kind <= fire_kind; // caller may change fire_kind now
                        end
                        if (state == st_clear_count) begin
                                saved_flag <= 1'b0;
                        end else if (state == st_save_shot) begin
                                saved_flag <= 1'b1;
                                saved_slot <= slot_index;
                        end
                end
        end

        // Moore outputs
        assign slot_clear = (state == st_clear_count);
        assign slot_count = (state == st_next_slot);
        assign save_shot  = (state == st_save_shot);
        assign shot_done  = (state == st_signal_done);
        assign shot_saved = (state == st_signal_done) && saved_flag;

        assign db_state   = state;

endmodule

`default_nettype wire

// ==== rtl/shot_register_top.sv ====
`default_nettype none

module shot_register_top
        import shot_pkg::*;
(
        input  wire logic                  clock,
        input  wire logic                  reset,

        // fire request and ship movement
        input  wire logic                  fire,
        input  wire shot_kind_e            fire_kind,
        input  wire logic                  move_left,
        input  wire logic                  move_right,

        // slot release and table read
        input  wire logic                  retire,
        input  wire logic [SLOT_BITS-1:0]  retire_slot,
        input  wire logic [SLOT_BITS-1:0]  read_slot,

        output logic                       shot_done,
        output logic                       shot_saved,
        output logic [SLOT_BITS-1:0]       saved_slot,
        output logic [SHOT_SLOTS-1:0]      slot_loaded,
        output logic [POS_BITS-1:0]        read_position,
        output shot_kind_e                 read_kind,
        output logic [POS_BITS-1:0]        ship_pos,
        output reg_state_e                 db_state
);

        logic                 slot_clear;
        logic                 slot_count;
        logic [SLOT_BITS-1:0] slot_index;
        logic                 slot_last;
        logic                 slot_busy;
        logic                 save_shot;
        shot_kind_e           save_kind;

        ship_position ship_position_i (
                .clock      (clock),
                .reset      (reset),
                .move_left  (move_left),
                .move_right (move_right),
                .ship_pos   (ship_pos)
        );

        slot_counter slot_counter_i (
                .clock      (clock),
                .reset      (reset),
                .slot_clear (slot_clear),
                .slot_count (slot_count),
                .slot_index (slot_index),
                .slot_last  (slot_last)
        );

        shot_table shot_table_i (
                .clock         (clock),
                .reset         (reset),
                .slot_index    (slot_index),
                .save_shot     (save_shot),
                .ship_pos      (ship_pos),
                .save_kind     (save_kind),
                .retire        (retire),
                .retire_slot   (retire_slot),
                .read_slot     (read_slot),
                .slot_busy     (slot_busy),
                .slot_loaded   (slot_loaded),
                .read_position (read_position),
                .read_kind     (read_kind)
        );

        shot_register_control shot_register_control_i (
                .clock      (clock),
                .reset      (reset),
                .fire       (fire),
                .fire_kind  (fire_kind),
                .slot_busy  (slot_busy),
                .slot_last  (slot_last),
                .slot_index (slot_index),
                .slot_clear (slot_clear),
                .slot_count (slot_count),
                .save_shot  (save_shot),
                .save_kind  (save_kind),
                .shot_done  (shot_done),
                .shot_saved (shot_saved),
                .saved_slot (saved_slot),
                .db_state   (db_state)
        );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
        output logic clock,
        output logic reset
);

        timeunit 1ns;
        timeprecision 1ps;

        localparam int HALF_PERIOD  = 4; // 8 ns clock
        localparam int RESET_CYCLES = 3;

        initial begin
                clock = 1'b0;
                forever #HALF_PERIOD clock = ~clock;
        end

        // release reset just after an edge so no flop sees it change on an edge
        initial begin
                reset = 1'b1;
                repeat (RESET_CYCLES) @(posedge clock);
                #1 reset = 1'b0;
        end

endmodule

`default_nettype wire

// ==== dv/shot_register_asserts.sv ====
`default_nettype none

module shot_register_asserts (
        input  wire logic clock,
        input  wire logic reset,
        input  wire logic fire,
        input  wire logic slot_busy,
        input  wire logic slot_clear,
        input  wire logic save_shot,
        input  wire logic shot_done
);

        timeunit 1ns;
        timeprecision 1ps;

        int   fail_count = 0; // failed assertions so far
        logic fire_seen;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        fire_seen <= 1'b0;
                end else if (fire) begin
                        fire_seen <= 1'b1;
                end
        end

        done_one_cycle: assert property (@(posedge clock) disable iff (reset)
                shot_done |=> !shot_done)
                else begin
                        fail_count++;
                        $error("shot_done stayed high for more than one cycle");
                end

        save_into_free: assert property (@(posedge clock) disable iff (reset)
                save_shot |-> !slot_busy)
                else begin
                        fail_count++;
                        $error("save_shot raised while the scanned slot is busy");
                end

        clear_or_save: assert property (@(posedge clock) disable iff (reset)
                !(slot_clear && save_shot))
                else begin
                        fail_count++;
                        $error("slot_clear and save_shot high together");
                end

        // no done pulse before the first request
        done_after_fire: assert property (@(posedge clock) disable iff (reset)
                shot_done |-> fire_seen)
                else begin
                        fail_count++;
                        $error("shot_done without any fire since reset");
                end

endmodule

bind shot_register_control shot_register_asserts shot_register_asserts_i (
        .clock      (clock),
        .reset      (reset),
        .fire       (fire),
        .slot_busy  (slot_busy),
        .slot_clear (slot_clear),
        .save_shot  (save_shot),
        .shot_done  (shot_done)
);

`default_nettype wire

// ==== dv/tb_shot_register.sv ====
`default_nettype none

module tb_shot_register
        import shot_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int DRIVE_DELAY   = 1;
        localparam int CYCLE_LIMIT   = 4000; // ~60 requests of 12 cycles plus moves, with margin
        localparam int RANDOM_ROUNDS = 48;
        localparam int M_INIT        = 0;
        localparam int M_IDLE        = 1;
        localparam int M_BUSY        = 2;

        logic clock;
        logic reset;

        logic                  fire;
        shot_kind_e            fire_kind;
        logic                  move_left;
        logic                  move_right;
        logic                  retire;
        logic [SLOT_BITS-1:0]  retire_slot;
        logic [SLOT_BITS-1:0]  read_slot;
        logic                  shot_done;
        logic                  shot_saved;
        logic [SLOT_BITS-1:0]  saved_slot;
        logic [SHOT_SLOTS-1:0] slot_loaded;
        logic [POS_BITS-1:0]   read_position;
        shot_kind_e            read_kind;
        logic [POS_BITS-1:0]   ship_pos;
        reg_state_e            db_state;

        int     errors = 0;
        int     cycle_count;
        integer seed;

        // reference model state
        int                    model_state;
        logic [POS_BITS-1:0]   model_pos;
        logic [SHOT_SLOTS-1:0] model_loaded;
        logic [POS_BITS-1:0]   model_pos_mem [SHOT_SLOTS];
        shot_kind_e            model_kind_mem [SHOT_SLOTS];
        shot_kind_e            model_kind;
        logic [POS_BITS-1:0]   model_fire_pos;
        logic                  model_will_save;
        logic [SLOT_BITS-1:0]  model_slot;
        int                    model_edges;     // edges since the fire was taken
        int                    model_done_edge;
        logic                  model_done;

        tb_clock_gen tb_clock_gen_i (
                .clock (clock),
                .reset (reset)
        );

        shot_register_top shot_register_top_i (
                .clock         (clock),
                .reset         (reset),
                .fire          (fire),
                .fire_kind     (fire_kind),
                .move_left     (move_left),
                .move_right    (move_right),
                .retire        (retire),
                .retire_slot   (retire_slot),
                .read_slot     (read_slot),
                .shot_done     (shot_done),
                .shot_saved    (shot_saved),
                .saved_slot    (saved_slot),
                .slot_loaded   (slot_loaded),
                .read_position (read_position),
                .read_kind     (read_kind),
                .ship_pos      (ship_pos),
                .db_state      (db_state)
        );

        // first free slot saves at edge 4+2k, a full table ends at edge 2*SHOT_SLOTS+1
        function automatic int scan_result(input logic [SHOT_SLOTS-1:0] loaded,
                                           output logic will_save,
                                           output logic [SLOT_BITS-1:0] slot);
                will_save = 1'b0;
                slot      = '0;
                for (int k = SHOT_SLOTS - 1; k >= 0; k--) begin
                        if (!loaded[k]) begin
                                will_save = 1'b1;
                                slot      = SLOT_BITS'(k); // lowest free one is kept
                        end
                end
                if (will_save) begin
                        return 4 + 2 * int'(slot);
                end
                return 2 * SHOT_SLOTS + 1;
        endfunction

        task automatic report_mismatch(input string what, input logic [31:0] got,
                                       input logic [31:0] expected);
                $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
                errors++;
        endtask

        // step to just after the next edge and drop all pulses
        task automatic next_cycle();
                @(posedge clock);
                #DRIVE_DELAY;
                fire       = 1'b0;
                move_left  = 1'b0;
                move_right = 1'b0;
                retire     = 1'b0;
        endtask

        task automatic move_ship(input int steps, input logic left, input logic right);
                repeat (steps) begin
                        next_cycle();
                        move_left  = left;
                        move_right = right;
                end
        endtask

        task automatic retire_shot(input logic [SLOT_BITS-1:0] slot);
                next_cycle();
                retire      = 1'b1;
                retire_slot = slot;
        endtask

        // extra_fire pulses fire during the scan and in the done cycle
        // clash retires the target slot on the edge that saves it
        task automatic fire_shot(input shot_kind_e kind, input logic extra_fire,
                                 input logic clash);
                logic                 will_save;
                logic [SLOT_BITS-1:0] slot;
                int                   done_edge;
                int                   n;

                next_cycle();
                while (model_state != M_IDLE) begin
                        next_cycle();
                end
                done_edge = scan_result(model_loaded, will_save, slot);
                fire      = 1'b1;
                fire_kind = kind;
                n         = 0;
                next_cycle(); // edge 0 took the request
                fire_kind = shot_kind_e'(~kind);
                while (!shot_done && n <= done_edge) begin
                        if (extra_fire && n == 1) begin
                                fire = 1'b1;
                        end
                        if (clash && will_save && n == done_edge - 1) begin
                                retire      = 1'b1;
                                retire_slot = slot;
                        end
                        next_cycle();
                        n++;
                end
                if (!shot_done) begin
                        $display("no shot_done within %0d cycles of the fire at %0t ns",
                                 done_edge + 1, $time);
                        errors++;
                end else if (extra_fire) begin
                        fire = 1'b1; // lands while the control leaves signal_done
                end
        endtask

        // reference model, stepped on each edge from the driven inputs
        always @(posedge clock or posedge reset) begin
                if (reset) begin
                        model_state     = M_INIT;
                        model_pos       = POS_RESET;
                        model_loaded    = '0;
                        model_kind      = kind_single;
                        model_fire_pos  = POS_RESET;
                        model_will_save = 1'b0;
                        model_slot      = '0;
                        model_edges     = 0;
                        model_done_edge = 0;
                        model_done      = 1'b0;
                end else begin
                        model_done = 1'b0;
                        if (retire) begin
                                model_loaded[retire_slot] = 1'b0; // a save on this edge wins
                        end
                        case (model_state)
                                M_INIT: model_state = M_IDLE;
                                M_IDLE: begin
                                        if (fire) begin
                                                model_done_edge = scan_result(model_loaded,
                                                                              model_will_save,
                                                                              model_slot);
                                                model_kind     = fire_kind;
                                                model_fire_pos = model_pos;
                                                model_edges    = 0;
                                                model_state    = M_BUSY;
                                        end
                                end
                                default: begin
                                        model_edges++;
                                        if (model_edges == model_done_edge) begin
                                                model_done = 1'b1;
                                                if (model_will_save) begin
                                                        model_loaded[model_slot]   = 1'b1;
                                                        model_pos_mem[model_slot]  = model_fire_pos;
                                                        model_kind_mem[model_slot] = model_kind;
                                                end
                                        end else if (model_edges > model_done_edge) begin
                                                model_state = M_IDLE;
                                        end
                                end
                        endcase
                        if (move_left && !move_right && model_pos != '0) begin
                                model_pos = model_pos - POS_BITS'(1);
                        end else if (move_right && !move_left && model_pos != POS_MAX) begin
                                model_pos = model_pos + POS_BITS'(1);
                        end
                end
        end

        // compare in mid cycle, where all outputs are settled
        always @(negedge clock) begin
                if (!reset) begin
                        if (ship_pos !== model_pos) begin
                                report_mismatch("ship_pos", 32'(ship_pos), 32'(model_pos));
                        end
                        if (slot_loaded !== model_loaded) begin
                                report_mismatch("slot_loaded", 32'(slot_loaded), 32'(model_loaded));
                        end
                        if (model_state == M_IDLE && db_state !== st_idle) begin
                                report_mismatch("db_state", 32'(db_state), 32'(st_idle));
                        end
                        if (model_state == M_INIT && db_state !== st_init) begin
                                report_mismatch("db_state", 32'(db_state), 32'(st_init));
                        end
                        if (model_done && !shot_done) begin
                                $display("shot_done missing %0d cycles after the fire, at %0t ns",
                                         model_done_edge, $time);
                                errors++;
                        end
                        if (shot_done && !model_done) begin
                                report_mismatch("cycles from fire to shot_done", 32'(model_edges),
                                                32'(model_done_edge));
                        end
                        if (shot_saved !== (model_done && model_will_save)) begin
                                report_mismatch("shot_saved", 32'(shot_saved),
                                                32'(model_done && model_will_save));
                        end
                        if (shot_done && model_will_save && saved_slot !== model_slot) begin
                                report_mismatch("saved_slot", 32'(saved_slot), 32'(model_slot));
                        end
                        if (model_loaded[read_slot]) begin
                                if (read_position !== model_pos_mem[read_slot]) begin
                                        report_mismatch("read_position", 32'(read_position),
                                                        32'(model_pos_mem[read_slot]));
                                end
                                if (read_kind !== model_kind_mem[read_slot]) begin
                                        report_mismatch("read_kind", 32'(read_kind),
                                                        32'(model_kind_mem[read_slot]));
                                end
                        end
                end
        end

        // read port walks over all slots
        always @(posedge clock) begin
                #DRIVE_DELAY;
                read_slot = read_slot + SLOT_BITS'(1);
        end

        initial begin
                cycle_count = 0;
                while (cycle_count < CYCLE_LIMIT) begin
                        @(posedge clock);
                        cycle_count++;
                end
                $display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
                $display("TEST RESULT: FAIL");
                $finish;
        end

        initial begin
                int          assert_fails;
                logic [31:0] rnd;

                seed        = 32'hfb1b5dde;
                fire        = 1'b0;
                fire_kind   = kind_single;
                move_left   = 1'b0;
                move_right  = 1'b0;
                retire      = 1'b0;
                retire_slot = '0;
                read_slot   = '0;

                // values while reset is still held
                @(posedge clock);
                @(negedge clock);
                if (db_state !== st_init) begin
                        report_mismatch("db_state in reset", 32'(db_state), 32'(st_init));
                end
                if (shot_done !== 1'b0) begin
                        report_mismatch("shot_done in reset", 32'(shot_done), 32'd0);
                end
                if (slot_loaded !== '0) begin
                        report_mismatch("slot_loaded in reset", 32'(slot_loaded), 32'd0);
                end
                if (ship_pos !== POS_RESET) begin
                        report_mismatch("ship_pos in reset", 32'(ship_pos), 32'(POS_RESET));
                end
                wait (reset == 1'b0);
                repeat (2) next_cycle();

                // moves into both limits and simultaneous pulses
                move_ship(10, 1'b0, 1'b1);
                next_cycle();
                if (ship_pos !== POS_MAX) begin
                        report_mismatch("ship_pos at right limit", 32'(ship_pos), 32'(POS_MAX));
                end
                move_ship(20, 1'b1, 1'b0);
                next_cycle();
                if (ship_pos !== '0) begin
                        report_mismatch("ship_pos at left limit", 32'(ship_pos), 32'd0);
                end
                move_ship(3, 1'b1, 1'b1);
                move_ship(6, 1'b0, 1'b1);
                move_ship(2, 1'b1, 1'b1);

                // empty table fills in order
                fire_shot(kind_single, 1'b0, 1'b0);
                move_ship(2, 1'b0, 1'b1);
                fire_shot(kind_spread, 1'b0, 1'b0);
                move_ship(4, 1'b1, 1'b0);
                fire_shot(kind_laser, 1'b0, 1'b0);
                fire_shot(kind_bomb, 1'b0, 1'b0);

                // full table drops the shot
                fire_shot(kind_laser, 1'b0, 1'b0);
                fire_shot(kind_single, 1'b0, 1'b0);

                // freed slots are reused
                retire_shot(1);
                fire_shot(kind_bomb, 1'b0, 1'b0);
                retire_shot(2);
                retire_shot(0);
                fire_shot(kind_spread, 1'b0, 1'b0);
                fire_shot(kind_laser, 1'b0, 1'b0);

                // stray fire pulses, then retire against save on the same slot
                retire_shot(3);
                fire_shot(kind_spread, 1'b1, 1'b0);
                repeat (3) next_cycle();
                retire_shot(2);
                fire_shot(kind_single, 1'b0, 1'b1);
                fire_shot(kind_bomb, 1'b0, 1'b0);

                repeat (RANDOM_ROUNDS) begin
                        rnd = $random(seed);
                        if (rnd[0] || rnd[1]) begin
                                fire_shot(shot_kind_e'(rnd[3:2]), 1'b0, 1'b0);
                        end
                        if (rnd[5:4] != 2'b00) begin
                                move_ship(int'(rnd[7:6]) + 1, rnd[8], rnd[9]);
                        end
                        if (rnd[10]) begin
                                retire_shot(rnd[13:12]);
                        end
                end

                repeat (4) next_cycle();
                assert_fails =
                        shot_register_top_i.shot_register_control_i.shot_register_asserts_i.fail_count;
                $display("run complete, %0d errors, %0d assertion failures", errors, assert_fails);
                if (errors == 0 && assert_fails == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/shot_pkg.sv
rtl/ship_position.sv
rtl/slot_counter.sv
rtl/shot_table.sv
rtl/shot_register_control.sv
rtl/shot_register_top.sv
dv/tb_clock_gen.sv
dv/shot_register_asserts.sv
dv/tb_shot_register.sv

// ==== Makefile ====
# Verilator build and run for the shot register testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_shot_register \
		-f files.f -Mdir $(OBJ_DIR) -o sim_shot_register

run: compile
	./$(OBJ_DIR)/sim_shot_register +verilator+error+limit+100 > sim.log 2>&1; \
	status=$$?; \
	cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" sim.log || \
		! grep -q "TEST RESULT: PASS" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) sim.log
